/* logic/soc_router_params.svh */
// ------------------------------------------------
// Address router widths and boot-hold length
// Six-region address map, bases and lengths
// Range end is base plus length, exclusive
// ------------------------------------------------
`ifndef SOC_ROUTER_PARAMS_SVH
`define SOC_ROUTER_PARAMS_SVH

// Widths
`define ROUTER_ADDR_W 32
`define BOOT_HOLD_W 7

// Cycles after reset release where debug requests are held off
`define BOOT_HOLD_CYCLES 64

// ------------------------------------------------
// Region map
// ------------------------------------------------
`define RGN_DEBUG_BASE 32'h0000_0000
`define RGN_DEBUG_LEN 32'h0000_1000
`define RGN_ROM_BASE 32'h0001_0000
`define RGN_ROM_LEN 32'h0001_0000
`define RGN_CLINT_BASE 32'h0200_0000
`define RGN_CLINT_LEN 32'h000C_0000
`define RGN_PLIC_BASE 32'h0C00_0000
`define RGN_PLIC_LEN 32'h0400_0000
`define RGN_APB_BASE 32'h1A10_0000
`define RGN_APB_LEN 32'h0010_0000
`define RGN_L2SPM_BASE 32'h1C00_0000
`define RGN_L2SPM_LEN 32'h0010_0000

`endif

/* logic/soc_router_pkg.sv */
// ------------------------------------------------
// Shared types of the address router
// Operation, region and response status enums
// ------------------------------------------------
package soc_router_pkg;

  // Request operation
  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } op_e;

  // Decoded target, NONE when no range matches
  typedef enum logic [2:0] {
    REGION_DEBUG = 3'd0,
    REGION_ROM   = 3'd1,
    REGION_CLINT = 3'd2,
    REGION_PLIC  = 3'd3,
    REGION_APB   = 3'd4,
    REGION_L2SPM = 3'd5,
    REGION_NONE  = 3'd6
  } region_e;

  // Response status
  typedef enum logic [1:0] {
    ST_OK     = 2'd0,
    ST_DECERR = 2'd1,
    ST_ROERR  = 2'd2,
    ST_HOLD   = 2'd3
  } status_e;

endpackage

/* logic/req_intake.sv */
// ------------------------------------------------
// Request intake stage
// Four-phase slave on the outside request link
// One-entry capture register toward the decoder
// ------------------------------------------------
`timescale 1ns/1ps
`include "soc_router_params.svh"

module req_intake (
  input  logic                      clk_i,
  input  logic                      ndmreset_n,
  input  logic                      req_i,
  input  logic [`ROUTER_ADDR_W-1:0] req_addr_i,
  input  soc_router_pkg::op_e       req_op_i,
  input  logic                      dec_ready_i,
  output logic                      ack_o,
  output logic                      dec_valid_o,
  output logic [`ROUTER_ADDR_W-1:0] dec_addr_o,
  output soc_router_pkg::op_e       dec_op_o
);

  logic                      ack_q;
  logic                      valid_q;
  logic                      capture;
  logic [`ROUTER_ADDR_W-1:0] addr_q;
  soc_router_pkg::op_e       op_q;

  // New phase only, ack still high means this one was taken already
  assign capture = req_i && !ack_q && !valid_q;

  // Four-phase ack state
  always_ff @(posedge clk_i or negedge ndmreset_n) begin : p_ack
    if (!ndmreset_n) begin
      ack_q <= 1'b0;
    end else if (capture) begin
      ack_q <= 1'b1;
    end else if (!req_i) begin
      ack_q <= 1'b0;
    end
  end

  // Stage register occupancy
  always_ff @(posedge clk_i or negedge ndmreset_n) begin : p_valid
    if (!ndmreset_n) begin
      valid_q <= 1'b0;
    end else if (capture) begin
      valid_q <= 1'b1;
    end else if (dec_ready_i) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin : p_payload
    if (capture) begin
      addr_q <= req_addr_i;
      op_q   <= req_op_i;
    end
  end

  assign ack_o       = ack_q;
  assign dec_valid_o = valid_q;
  assign dec_addr_o  = addr_q;
  assign dec_op_o    = op_q;

endmodule

/* logic/addr_map_decode.sv */
// ------------------------------------------------
// Address map decode stage
// Range compare against the six-region map
// Registered region and operation out
// ------------------------------------------------
`timescale 1ns/1ps
`include "soc_router_params.svh"

module addr_map_decode (
  input  logic                      clk_i,
  input  logic                      ndmreset_n,
  input  logic                      in_valid_i,
  input  logic [`ROUTER_ADDR_W-1:0] in_addr_i,
  input  soc_router_pkg::op_e       in_op_i,
  input  logic                      out_ready_i,
  output logic                      in_ready_o,
  output logic                      out_valid_o,
  output soc_router_pkg::region_e   out_region_o,
  output soc_router_pkg::op_e       out_op_o
);

  logic                    valid_q;
  logic                    accept;
  soc_router_pkg::region_e region_d;
  soc_router_pkg::region_e region_q;
  soc_router_pkg::op_e     op_q;

  // Start inclusive, end exclusive; offset form cannot overflow
  function automatic logic in_range(input logic [`ROUTER_ADDR_W-1:0] addr,
                                    input logic [`ROUTER_ADDR_W-1:0] base,
                                    input logic [`ROUTER_ADDR_W-1:0] len);
    in_range = (addr >= base) && ((addr - base) < len);
  endfunction

  // ------------------------------------------------
  // Region lookup
  // ------------------------------------------------
  always_comb begin : p_lookup
    region_d = soc_router_pkg::REGION_NONE;
    if (in_range(in_addr_i, `RGN_DEBUG_BASE, `RGN_DEBUG_LEN)) begin
      region_d = soc_router_pkg::REGION_DEBUG;
    end else if (in_range(in_addr_i, `RGN_ROM_BASE, `RGN_ROM_LEN)) begin
      region_d = soc_router_pkg::REGION_ROM;
    end else if (in_range(in_addr_i, `RGN_CLINT_BASE, `RGN_CLINT_LEN)) begin
      region_d = soc_router_pkg::REGION_CLINT;
    end else if (in_range(in_addr_i, `RGN_PLIC_BASE, `RGN_PLIC_LEN)) begin
      region_d = soc_router_pkg::REGION_PLIC;
    end else if (in_range(in_addr_i, `RGN_APB_BASE, `RGN_APB_LEN)) begin
      region_d = soc_router_pkg::REGION_APB;
    end else if (in_range(in_addr_i, `RGN_L2SPM_BASE, `RGN_L2SPM_LEN)) begin
      region_d = soc_router_pkg::REGION_L2SPM;
    end
  end

  // Output register frees up in the same cycle it is drained
  assign in_ready_o = !valid_q || out_ready_i;
  assign accept     = in_valid_i && in_ready_o;

  always_ff @(posedge clk_i or negedge ndmreset_n) begin : p_valid
    if (!ndmreset_n) begin
      valid_q <= 1'b0;
    end else if (accept) begin
      valid_q <= 1'b1;
    end else if (out_ready_i) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin : p_payload
    if (accept) begin
      region_q <= region_d;
      op_q     <= in_op_i;
    end
  end

  assign out_valid_o  = valid_q;
  assign out_region_o = region_q;
  assign out_op_o     = op_q;

endmodule

/* logic/resp_issuer.sv */
// ------------------------------------------------
// Response stage
// Status resolution and boot-hold counter
// Four-phase master on the response link
// ------------------------------------------------
`timescale 1ns/1ps
`include "soc_router_params.svh"

module resp_issuer (
  input  logic                    clk_i,
  input  logic                    ndmreset_n,
  input  logic                    in_valid_i,
  input  soc_router_pkg::region_e in_region_i,
  input  soc_router_pkg::op_e     in_op_i,
  input  logic                    rsp_ack_i,
  output logic                    in_ready_o,
  output logic                    rsp_req_o,
  output soc_router_pkg::region_e rsp_region_o,
  output soc_router_pkg::status_e rsp_status_o
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_LOADED,
    S_REQ,
    S_RELEASE
  } rsp_state_e;

  rsp_state_e              state_q;
  rsp_state_e              state_d;
  logic                    accept;
  logic [`BOOT_HOLD_W-1:0] hold_cnt_q;
  soc_router_pkg::region_e region_q;
  soc_router_pkg::status_e status_q;

  // Priority: decode error, then read-only, then boot hold
  function automatic soc_router_pkg::status_e resolve(input soc_router_pkg::region_e rgn,
                                                       input soc_router_pkg::op_e op,
                                                       input logic hold);
    if (rgn == soc_router_pkg::REGION_NONE) begin
      resolve = soc_router_pkg::ST_DECERR;
    end else if (rgn == soc_router_pkg::REGION_ROM && op == soc_router_pkg::OP_WRITE) begin
      resolve = soc_router_pkg::ST_ROERR;
    end else if (rgn == soc_router_pkg::REGION_DEBUG && hold) begin
      resolve = soc_router_pkg::ST_HOLD;
    end else begin
      resolve = soc_router_pkg::ST_OK;
    end
  endfunction

  // Keeps debug away while boot code runs, stops at zero
  always_ff @(posedge clk_i or negedge ndmreset_n) begin : p_hold_cnt
    if (!ndmreset_n) begin
      hold_cnt_q <= `BOOT_HOLD_W'(`BOOT_HOLD_CYCLES);
    end else if (hold_cnt_q != '0) begin
      hold_cnt_q <= hold_cnt_q - 1'b1;
    end
  end

  assign in_ready_o = (state_q == S_IDLE);
  assign accept     = in_valid_i && in_ready_o;

  // ------------------------------------------------
  // Response handshake FSM
  // ------------------------------------------------
  always_comb begin : p_next
    state_d = state_q;
    case (state_q)
      S_IDLE:    if (in_valid_i) state_d = S_LOADED;
      S_LOADED:  state_d = S_REQ;
      S_REQ:     if (rsp_ack_i) state_d = S_RELEASE;
      S_RELEASE: if (!rsp_ack_i) state_d = S_IDLE;
      default:   state_d = S_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge ndmreset_n) begin : p_state
    if (!ndmreset_n) begin
      state_q <= S_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin : p_payload
    if (accept) begin
      region_q <= in_region_i;
      status_q <= resolve(in_region_i, in_op_i, hold_cnt_q != '0);
    end
  end

  assign rsp_req_o    = (state_q == S_REQ);
  assign rsp_region_o = region_q;
  assign rsp_status_o = status_q;

endmodule

/* logic/soc_addr_router.sv */
// ------------------------------------------------
// Address router top level
// Intake, decode and response stages in a line
// ------------------------------------------------
`timescale 1ns/1ps
`include "soc_router_params.svh"

module soc_addr_router (
  input  logic                      clk_i,
  input  logic                      ndmreset_n,
  input  logic                      req_i,
  input  logic [`ROUTER_ADDR_W-1:0] req_addr_i,
  input  soc_router_pkg::op_e       req_op_i,
  input  logic                      rsp_ack_i,
  output logic                      ack_o,
  output logic                      rsp_req_o,
  output soc_router_pkg::region_e   rsp_region_o,
  output soc_router_pkg::status_e   rsp_status_o
);

  // Intake to decode
  logic                      dec_valid;
  logic                      dec_ready;
  logic [`ROUTER_ADDR_W-1:0] dec_addr;
  soc_router_pkg::op_e       dec_op;

  // Decode to response
  logic                      iss_valid;
  logic                      iss_ready;
  soc_router_pkg::region_e   iss_region;
  soc_router_pkg::op_e       iss_op;

  req_intake i_req_intake (
    .clk_i       ( clk_i      ),
    .ndmreset_n  ( ndmreset_n ),
    .req_i       ( req_i      ),
    .req_addr_i  ( req_addr_i ),
    .req_op_i    ( req_op_i   ),
    .dec_ready_i ( dec_ready  ),
    .ack_o       ( ack_o      ),
    .dec_valid_o ( dec_valid  ),
    .dec_addr_o  ( dec_addr   ),
    .dec_op_o    ( dec_op     )
  );

  addr_map_decode i_addr_map_decode (
    .clk_i        ( clk_i      ),
    .ndmreset_n   ( ndmreset_n ),
    .in_valid_i   ( dec_valid  ),
    .in_addr_i    ( dec_addr   ),
    .in_op_i      ( dec_op     ),
    .out_ready_i  ( iss_ready  ),
    .in_ready_o   ( dec_ready  ),
    .out_valid_o  ( iss_valid  ),
    .out_region_o ( iss_region ),
    .out_op_o     ( iss_op     )
  );

  resp_issuer i_resp_issuer (
    .clk_i        ( clk_i        ),
    .ndmreset_n   ( ndmreset_n   ),
    .in_valid_i   ( iss_valid    ),
    .in_region_i  ( iss_region   ),
    .in_op_i      ( iss_op       ),
    .rsp_ack_i    ( rsp_ack_i    ),
    .in_ready_o   ( iss_ready    ),
    .rsp_req_o    ( rsp_req_o    ),
    .rsp_region_o ( rsp_region_o ),
    .rsp_status_o ( rsp_status_o )
  );

endmodule

/* tb/soc_addr_router_checker.sv */
// ------------------------------------------------
// Handshake assertions for the address router
// Bound to the top level
// ------------------------------------------------
`timescale 1ns/1ps

module soc_addr_router_checker (
  input logic                    clk_i,
  input logic                    ndmreset_n,
  input logic                    req_i,
  input logic                    ack_o,
  input logic                    rsp_req_o,
  input logic                    rsp_ack_i,
  input soc_router_pkg::region_e rsp_region_o,
  input soc_router_pkg::status_e rsp_status_o
);

  // Ack only answers a live request
  a_ack_needs_req: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    $rose(ack_o) |-> $past(req_i)) else $error("ack_o rose without req_i");

  // Response payload frozen until acknowledged
  a_rsp_stable: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    (rsp_req_o && !rsp_ack_i) |=> ($stable(rsp_region_o) && $stable(rsp_status_o)))
    else $error("Response payload changed during the handshake");

  // No new response before the old ack is released
  a_rsp_wait_ack_low: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    (!rsp_req_o && rsp_ack_i) |=> !rsp_req_o)
    else $error("rsp_req_o rose while rsp_ack_i was still high");

  a_reset_quiet: assert property (@(posedge clk_i)
    !ndmreset_n |-> (!ack_o && !rsp_req_o)) else $error("Handshake active in reset");

endmodule

bind soc_addr_router soc_addr_router_checker u_checker (.*);

/* tb/soc_addr_router_tb.sv */
// ------------------------------------------------
// Testbench for the address router
// Four-phase drivers, reference model, comparator
// ------------------------------------------------
`timescale 1ns/1ps
`include "soc_router_params.svh"

module soc_addr_router_tb;

  // About 100 requests of up to 20 cycles each, doubled
  localparam int TIMEOUT_CYCLES = 100 * 20 * 2;

  logic                      clk_i;
  logic                      ndmreset_n;
  logic                      req_i;
  logic [`ROUTER_ADDR_W-1:0] req_addr_i;
  soc_router_pkg::op_e       req_op_i;
  logic                      rsp_ack_i;
  logic                      ack_o;
  logic                      rsp_req_o;
  soc_router_pkg::region_e   rsp_region_o;
  soc_router_pkg::status_e   rsp_status_o;

  logic [`ROUTER_ADDR_W-1:0] rgn_base [6] = '{`RGN_DEBUG_BASE, `RGN_ROM_BASE, `RGN_CLINT_BASE,
                                              `RGN_PLIC_BASE, `RGN_APB_BASE, `RGN_L2SPM_BASE};
  logic [`ROUTER_ADDR_W-1:0] rgn_len [6]  = '{`RGN_DEBUG_LEN, `RGN_ROM_LEN, `RGN_CLINT_LEN,
                                              `RGN_PLIC_LEN, `RGN_APB_LEN, `RGN_L2SPM_LEN};
  soc_router_pkg::region_e   exp_region_q [$];
  soc_router_pkg::status_e   exp_status_q [$];
  integer                    seed = 32'h587e;
  integer                    ack_seed = 32'h587e;
  int                        cycle_cnt = 0;
  int                        release_cycle = 0;
  logic                      ack_delay_en = 1'b0;
  logic                      rsp_req_seen = 1'b0;

  soc_addr_router dut_i (.*);

  initial begin : clk_gen
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // Region table walk, then the status priority
  function automatic void expected_route(input logic [`ROUTER_ADDR_W-1:0] addr,
                                         input soc_router_pkg::op_e op, input logic hold,
                                         output soc_router_pkg::region_e rgn,
                                         output soc_router_pkg::status_e st);
    rgn = soc_router_pkg::REGION_NONE;
    for (int i = 0; i < 6; i++) begin
      if (addr >= rgn_base[i] && {1'b0, addr} < {1'b0, rgn_base[i]} + rgn_len[i]) begin
        rgn = soc_router_pkg::region_e'(i);
      end
    end
    st = (rgn == soc_router_pkg::REGION_NONE) ? soc_router_pkg::ST_DECERR :
         (rgn == soc_router_pkg::REGION_ROM && op == soc_router_pkg::OP_WRITE) ?
         soc_router_pkg::ST_ROERR :
         (rgn == soc_router_pkg::REGION_DEBUG && hold) ? soc_router_pkg::ST_HOLD :
         soc_router_pkg::ST_OK;
  endfunction

  task automatic check_region(input soc_router_pkg::region_e exp,
                              input soc_router_pkg::region_e act);
    if (act !== exp) begin
      $display("[ERROR] %0t ns rsp_region_o expected %s actual %s", $time, exp.name(),
               act.name());
      $display("Test failures found");
      $fatal(1, "Region mismatch");
    end
  endtask

  task automatic check_status(input soc_router_pkg::status_e exp,
                              input soc_router_pkg::status_e act);
    if (act !== exp) begin
      $display("[ERROR] %0t ns rsp_status_o expected %s actual %s", $time, exp.name(),
               act.name());
      $display("Test failures found");
      $fatal(1, "Status mismatch");
    end
  endtask

  task automatic step_cycle();
    @(posedge clk_i);
    #2;
  endtask

  // ------------------------------------------------
  // Request driver and random stimulus
  // ------------------------------------------------
  task automatic send_req(input logic [`ROUTER_ADDR_W-1:0] addr, input soc_router_pkg::op_e op);
    soc_router_pkg::region_e rgn;
    soc_router_pkg::status_e st;
    expected_route(addr, op, (cycle_cnt - release_cycle) < `BOOT_HOLD_CYCLES, rgn, st);
    exp_region_q.push_back(rgn);
    exp_status_q.push_back(st);
    req_addr_i = addr;
    req_op_i   = op;
    req_i      = 1'b1;
    while (!ack_o) step_cycle();
    req_i = 1'b0;
    while (ack_o) step_cycle();
  endtask

  // Mostly inside a region, some just past an end, some anywhere
  task automatic send_random();
    int unsigned               sel;
    int unsigned               idx;
    logic [31:0]               rnd;
    logic [`ROUTER_ADDR_W-1:0] addr;
    sel  = {$random(seed)} % 8;
    idx  = {$random(seed)} % 6;
    rnd  = $random(seed);
    addr = $random(seed);
    if (sel < 6) begin
      addr = rgn_base[sel] + (addr % rgn_len[sel]);
    end else if (sel == 6) begin
      addr = rgn_base[idx] + rgn_len[idx] + (addr % 16);
    end
    send_req(addr, soc_router_pkg::op_e'(rnd[0]));
  endtask

  task automatic wait_drain();
    while (exp_region_q.size() != 0 || rsp_req_o || rsp_ack_i) step_cycle();
  endtask

  initial begin : rsp_acker
    int unsigned delay;
    forever begin
      step_cycle();
      if (rsp_req_o && !rsp_ack_i) begin
        delay = ack_delay_en ? {$random(ack_seed)} % 5 : 0;
        repeat (delay) step_cycle();
        rsp_ack_i = 1'b1;
        while (rsp_req_o) step_cycle();
        rsp_ack_i = 1'b0;
      end
    end
  end

  always @(negedge clk_i) begin : compare_rsp
    logic rise;
    rise = rsp_req_o && !rsp_req_seen;
    rsp_req_seen = rsp_req_o;
    if (rise && exp_region_q.size() == 0) begin
      $display("Response at %0t ns with no request outstanding", $time);
      $display("Test failures found");
      $fatal(1, "Unexpected response");
    end else if (rise) begin
      check_region(exp_region_q.pop_front(), rsp_region_o);
      check_status(exp_status_q.pop_front(), rsp_status_o);
    end
  end

  always @(posedge clk_i) begin : watchdog
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, the router stopped responding", cycle_cnt);
      $display("Test failures found");
      $fatal(1, "Timeout");
    end
  end

  // ------------------------------------------------
  // Test sequence
  // ------------------------------------------------
  initial begin : main
    ndmreset_n = 1'b1;
    req_i      = 1'b0;
    req_addr_i = '0;
    req_op_i   = soc_router_pkg::OP_READ;
    rsp_ack_i  = 1'b0;
    #1 ndmreset_n = 1'b0;
    repeat (10) @(posedge clk_i);
    #2 ndmreset_n = 1'b1;
    release_cycle = cycle_cnt;
    // Debug read inside the boot-hold window, then well after it
    repeat (3) step_cycle();
    send_req(`RGN_DEBUG_BASE + 32'h40, soc_router_pkg::OP_READ);
    wait_drain();
    repeat (100) step_cycle();
    send_req(`RGN_DEBUG_BASE + 32'h40, soc_router_pkg::OP_READ);
    for (int i = 0; i < 6; i++) begin
      send_req(rgn_base[i], soc_router_pkg::OP_READ);
      send_req(rgn_base[i] + rgn_len[i] / 2, soc_router_pkg::OP_READ);
      send_req(rgn_base[i] + rgn_len[i] - 1, soc_router_pkg::OP_READ);
      send_req(rgn_base[i] + rgn_len[i], soc_router_pkg::OP_READ);
    end
    // Gaps between regions and the top of the space
    send_req(32'h0000_8000, soc_router_pkg::OP_READ);
    send_req(32'h0100_0000, soc_router_pkg::OP_READ);
    send_req(32'h1B00_0000, soc_router_pkg::OP_READ);
    send_req(32'hFFFF_FFFC, soc_router_pkg::OP_READ);
    for (int i = 1; i < 6; i++) begin
      send_req(rgn_base[i] + 32'h10, soc_router_pkg::OP_WRITE);
    end
    wait_drain();
    ack_delay_en = 1'b1;
    repeat (60) send_random();
    wait_drain();
    // Idle window so a stray extra response still reaches the comparator
    repeat (20) step_cycle();
    $display("All tests passed!");
    $finish;
  end

endmodule

/* soc_addr_router.f */
+incdir+logic
logic/soc_router_pkg.sv
logic/req_intake.sv
logic/addr_map_decode.sv
logic/resp_issuer.sv
logic/soc_addr_router.sv
tb/soc_addr_router_checker.sv
tb/soc_addr_router_tb.sv
